// File: include/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// input queue entries, also the upstream credits after reset
`define RV_IN_DEPTH 4

// commit credits held by the result stage after reset
`define RV_COMMIT_CREDITS 2

`endif

// File: hdl/rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] rv_word_t;

    // rv32i major opcodes
    typedef enum logic [6:0] {
        OPC_LOAD     = 7'b0000011,
        OPC_MISC_MEM = 7'b0001111,
        OPC_OP_IMM   = 7'b0010011,
        OPC_AUIPC    = 7'b0010111,
        OPC_STORE    = 7'b0100011,
        OPC_OP       = 7'b0110011,
        OPC_LUI      = 7'b0110111,
        OPC_BRANCH   = 7'b1100011,
        OPC_JALR     = 7'b1100111,
        OPC_JAL      = 7'b1101111,
        OPC_SYSTEM   = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B   // lui
    } alu_op_e;

    typedef struct packed {
        rv_word_t pc;
        rv_word_t instr;
    } instr_pkt_t;

    typedef struct packed {
        rv_word_t   pc;
        rv_word_t   instr;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
        rv_word_t   imm;       // already sign extended for the opcode
        alu_op_e    alu_op;
        logic       a_is_pc;
        logic       b_is_imm;
        logic       is_branch;
        logic       is_jal;
        logic       is_jalr;
        logic [2:0] funct3;    // branch condition
        logic       rd_we;
        logic       illegal;
    } decoded_op_t;

    typedef struct packed {
        rv_word_t   pc;
        rv_word_t   instr;
        logic [4:0] rd;
        rv_word_t   rd_val;
        logic       rd_we;
        logic       taken;
        rv_word_t   next_pc;
        logic       illegal;
    } exe_result_t;

    // as exe_result_t, rd_we is low for x0
    typedef struct packed {
        rv_word_t   pc;
        rv_word_t   instr;
        logic [4:0] rd;
        rv_word_t   rd_val;
        logic       rd_we;
        logic       taken;
        rv_word_t   next_pc;
        logic       illegal;
    } commit_t;

endpackage

// File: hdl/rv_input_queue.sv
`include "rv_defines.svh"

module rv_input_queue (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               push_i,
    input  rv_pkg::instr_pkt_t push_data_i,
    input  logic               pop_i,
    output logic               head_valid_o,
    output rv_pkg::instr_pkt_t head_o,
    output logic               credit_o
);
    import rv_pkg::*;

    localparam int DEPTH = `RV_IN_DEPTH;
    localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW    = $clog2(DEPTH + 1);

    instr_pkt_t     mem [DEPTH];
    logic [PW-1:0]  wr_ptr;
    logic [PW-1:0]  rd_ptr;
    logic [CW-1:0]  count;
    logic           do_pop;
    logic           full;

    assign full         = (count == CW'(DEPTH));
    assign head_valid_o = (count != '0);
    assign head_o       = mem[rd_ptr];
    assign do_pop       = pop_i && head_valid_o;

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            if (push_i) wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count    <= count + CW'(push_i) - CW'(do_pop);
            credit_o <= do_pop;   // one credit back per packet taken
        end
    end

    // upstream may only push while holding a credit
    a_no_push_when_full: assert property (@(posedge clk) disable iff (rst_i)
        !(push_i && full))
        else $error("input queue overflow, credit rule broken upstream");

endmodule

// File: hdl/rv_pipe_reg.sv
module rv_pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     ready_o,
    output logic     valid_o,
    output payload_t data_o,
    input  logic     ready_i
);

    assign ready_o = !valid_o || ready_i;   // empty or draining

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else if (ready_o) begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (ready_o && valid_i) begin
            data_o <= data_i;
        end
    end

    a_hold_stable: assert property (@(posedge clk) disable iff (rst_i)
        (valid_o && !ready_i) |=> (valid_o && $stable(data_o)))
        else $error("stage register changed while stalled");

endmodule

// File: hdl/rv_regfile.sv
module rv_regfile (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             we_i,
    input  logic [4:0]       waddr_i,
    input  rv_pkg::rv_word_t wdata_i,
    input  logic [4:0]       raddr1_i,
    input  logic [4:0]       raddr2_i,
    output rv_pkg::rv_word_t rdata1_o,
    output rv_pkg::rv_word_t rdata2_o
);
    import rv_pkg::*;

    rv_word_t regs [32];
    logic     wr_en;

    assign wr_en = we_i && (waddr_i != 5'd0);   // x0 never written

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // write-through so the reader sees this cycle's write
    always_comb begin
        rdata1_o = regs[raddr1_i];
        rdata2_o = regs[raddr2_i];
        if (wr_en && waddr_i == raddr1_i) rdata1_o = wdata_i;
        if (wr_en && waddr_i == raddr2_i) rdata2_o = wdata_i;
    end

endmodule

// File: hdl/rv_decode.sv
module rv_decode (
    input  logic                head_valid_i,
    input  rv_pkg::instr_pkt_t  head_i,
    output logic                pop_o,
    output logic                op_valid_o,
    output rv_pkg::decoded_op_t op_o,
    input  logic                op_ready_i
);
    import rv_pkg::*;

    rv_word_t   ins;
    opcode_e    opcode;
    logic [2:0] funct3;
    rv_word_t   imm_i;
    rv_word_t   imm_u;
    rv_word_t   imm_b;
    rv_word_t   imm_j;
    alu_op_e    arith_op;

    assign ins    = head_i.instr;
    assign opcode = opcode_e'(ins[6:0]);
    assign funct3 = ins[14:12];

    assign imm_i = {{20{ins[31]}}, ins[31:20]};
    assign imm_u = {ins[31:12], 12'b0};
    assign imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    assign imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};

    assign op_valid_o = head_valid_i;
    assign pop_o      = head_valid_i && op_ready_i;

    // shared by OP and OP-IMM, bit 30 picks sub and sra
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == OPC_OP && ins[30]) ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = ins[30] ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        op_o           = '0;
        op_o.pc        = head_i.pc;
        op_o.instr     = ins;
        op_o.rs1       = ins[19:15];
        op_o.rs2       = ins[24:20];
        op_o.rd        = ins[11:7];
        op_o.funct3    = funct3;
        op_o.alu_op    = ALU_ADD;
        case (opcode)
            OPC_OP: begin
                op_o.alu_op = arith_op;
                op_o.rd_we  = 1'b1;
            end
            OPC_OP_IMM: begin
                op_o.imm      = imm_i;   // shamt sits in imm[4:0]
                op_o.alu_op   = arith_op;
                op_o.b_is_imm = 1'b1;
                op_o.rd_we    = 1'b1;
            end
            OPC_LUI: begin
                op_o.imm      = imm_u;
                op_o.alu_op   = ALU_PASS_B;
                op_o.b_is_imm = 1'b1;
                op_o.rd_we    = 1'b1;
            end
            OPC_AUIPC: begin
                op_o.imm      = imm_u;
                op_o.a_is_pc  = 1'b1;
                op_o.b_is_imm = 1'b1;
                op_o.rd_we    = 1'b1;
            end
            OPC_JAL: begin
                op_o.imm    = imm_j;
                op_o.is_jal = 1'b1;
                op_o.rd_we  = 1'b1;
            end
            OPC_JALR: begin
                op_o.imm      = imm_i;
                op_o.b_is_imm = 1'b1;   // alu forms rs1 + imm
                op_o.is_jalr  = 1'b1;
                op_o.rd_we    = 1'b1;
            end
            OPC_BRANCH: begin
                op_o.imm       = imm_b;
                op_o.is_branch = 1'b1;
            end
            default: begin
                op_o.illegal = 1'b1;   // loads, stores and the rest
            end
        endcase
    end

endmodule

// File: hdl/rv_execute.sv
module rv_execute (
    input  logic                op_valid_i,
    input  rv_pkg::decoded_op_t op_i,
    output logic                op_ready_o,
    output logic [4:0]          rs1_addr_o,
    output logic [4:0]          rs2_addr_o,
    input  rv_pkg::rv_word_t    rs1_data_i,
    input  rv_pkg::rv_word_t    rs2_data_i,
    input  logic                fwd_valid_i,
    input  rv_pkg::exe_result_t fwd_i,
    output logic                res_valid_o,
    output rv_pkg::exe_result_t res_o,
    input  logic                res_ready_i
);
    import rv_pkg::*;

    rv_word_t rs1_val;
    rv_word_t rs2_val;
    rv_word_t opa;
    rv_word_t opb;
    rv_word_t alu_out;
    rv_word_t pc_plus4;
    logic     fwd_hit1;
    logic     fwd_hit2;
    logic     cond;

    assign rs1_addr_o = op_i.rs1;
    assign rs2_addr_o = op_i.rs2;

    // record in the result register wins over the register file
    assign fwd_hit1 = fwd_valid_i && fwd_i.rd_we && fwd_i.rd == op_i.rs1 && op_i.rs1 != 5'd0;
    assign fwd_hit2 = fwd_valid_i && fwd_i.rd_we && fwd_i.rd == op_i.rs2 && op_i.rs2 != 5'd0;
    assign rs1_val  = fwd_hit1 ? fwd_i.rd_val : rs1_data_i;
    assign rs2_val  = fwd_hit2 ? fwd_i.rd_val : rs2_data_i;

    assign opa      = op_i.a_is_pc ? op_i.pc : rs1_val;
    assign opb      = op_i.b_is_imm ? op_i.imm : rs2_val;
    assign pc_plus4 = op_i.pc + 32'd4;

    always_comb begin
        case (op_i.alu_op)
            ALU_SUB:    alu_out = opa - opb;
            ALU_SLL:    alu_out = opa << opb[4:0];
            ALU_SLT:    alu_out = {31'b0, $signed(opa) < $signed(opb)};
            ALU_SLTU:   alu_out = {31'b0, opa < opb};
            ALU_XOR:    alu_out = opa ^ opb;
            ALU_SRL:    alu_out = opa >> opb[4:0];
            ALU_SRA:    alu_out = $signed(opa) >>> opb[4:0];
            ALU_OR:     alu_out = opa | opb;
            ALU_AND:    alu_out = opa & opb;
            ALU_PASS_B: alu_out = opb;
            default:    alu_out = opa + opb;
        endcase
    end

    always_comb begin
        case (op_i.funct3)
            3'b000:  cond = (rs1_val == rs2_val);                   // beq
            3'b001:  cond = (rs1_val != rs2_val);                   // bne
            3'b100:  cond = ($signed(rs1_val) < $signed(rs2_val));  // blt
            3'b101:  cond = ($signed(rs1_val) >= $signed(rs2_val)); // bge
            3'b110:  cond = (rs1_val < rs2_val);                    // bltu
            3'b111:  cond = (rs1_val >= rs2_val);                   // bgeu
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        res_o         = '0;
        res_o.pc      = op_i.pc;
        res_o.instr   = op_i.instr;
        res_o.rd      = op_i.rd;
        res_o.rd_we   = op_i.rd_we;
        res_o.illegal = op_i.illegal;
        res_o.rd_val  = (op_i.is_jal || op_i.is_jalr) ? pc_plus4 : alu_out;
        res_o.next_pc = pc_plus4;
        if (op_i.is_branch && cond) begin
            res_o.taken   = 1'b1;
            res_o.next_pc = op_i.pc + op_i.imm;
        end else if (op_i.is_jal) begin
            res_o.taken   = 1'b1;   // jumps always redirect
            res_o.next_pc = op_i.pc + op_i.imm;
        end else if (op_i.is_jalr) begin
            res_o.taken   = 1'b1;
            res_o.next_pc = {alu_out[31:1], 1'b0};
        end
    end

    assign res_valid_o = op_valid_i;
    assign op_ready_o  = res_ready_i;

endmodule

// File: hdl/rv_result.sv
`include "rv_defines.svh"

module rv_result (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                res_valid_i,
    input  rv_pkg::exe_result_t res_i,
    output logic                res_ready_o,
    output logic                rf_we_o,
    output logic [4:0]          rf_waddr_o,
    output rv_pkg::rv_word_t    rf_wdata_o,
    output logic                commit_valid_o,
    output rv_pkg::commit_t     commit_o,
    input  logic                commit_credit_i
);
    import rv_pkg::*;

    // one spare count so an overflow stays visible
    localparam int CW = $clog2(`RV_COMMIT_CREDITS + 2);

    logic [CW-1:0] credits;
    logic          take;

    assign res_ready_o = (credits != '0);
    assign take        = res_valid_i && res_ready_o;

    assign rf_we_o    = take && res_i.rd_we;
    assign rf_waddr_o = res_i.rd;
    assign rf_wdata_o = res_i.rd_val;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            credits        <= CW'(`RV_COMMIT_CREDITS);
            commit_valid_o <= 1'b0;
        end else begin
            credits        <= credits - CW'(take) + CW'(commit_credit_i);
            commit_valid_o <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            commit_o         <= commit_t'(res_i);
            commit_o.rd_we   <= res_i.rd_we && (res_i.rd != 5'd0);
        end
    end

    // sink returned more credits than it was ever given
    a_credit_bound: assert property (@(posedge clk) disable iff (rst_i)
        credits <= CW'(`RV_COMMIT_CREDITS))
        else $error("commit credit count above %0d", `RV_COMMIT_CREDITS);

endmodule

// File: hdl/rv_core.sv
module rv_core (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               in_valid_i,
    input  rv_pkg::instr_pkt_t in_pkt_i,
    output logic               in_credit_o,
    output logic               commit_valid_o,
    output rv_pkg::commit_t    commit_o,
    input  logic               commit_credit_i
);
    import rv_pkg::*;

    instr_pkt_t  head;
    logic        head_valid, pop;
    decoded_op_t dec_op, exe_op;
    logic        dec_valid, dec_ready;
    logic        exe_valid, exe_ready;
    exe_result_t exe_res, res_rec;
    logic        exe_res_valid, exe_res_ready;
    logic        res_valid, res_ready;
    logic [4:0]  rs1_addr, rs2_addr, rf_waddr;
    rv_word_t    rs1_data, rs2_data, rf_wdata;
    logic        rf_we;

    rv_input_queue u_queue (
        .clk(clk), .rst_i(rst_i),
        .push_i(in_valid_i), .push_data_i(in_pkt_i),
        .pop_i(pop), .head_valid_o(head_valid), .head_o(head),
        .credit_o(in_credit_o)
    );

    rv_decode u_decode (
        .head_valid_i(head_valid), .head_i(head), .pop_o(pop),
        .op_valid_o(dec_valid), .op_o(dec_op), .op_ready_i(dec_ready)
    );

    rv_pipe_reg #(.payload_t(decoded_op_t)) u_dec_exe (
        .clk(clk), .rst_i(rst_i),
        .valid_i(dec_valid), .data_i(dec_op), .ready_o(dec_ready),
        .valid_o(exe_valid), .data_o(exe_op), .ready_i(exe_ready)
    );

    rv_execute u_execute (
        .op_valid_i(exe_valid), .op_i(exe_op), .op_ready_o(exe_ready),
        .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .fwd_valid_i(res_valid), .fwd_i(res_rec),   // forward from result register
        .res_valid_o(exe_res_valid), .res_o(exe_res), .res_ready_i(exe_res_ready)
    );

    rv_pipe_reg #(.payload_t(exe_result_t)) u_exe_res (
        .clk(clk), .rst_i(rst_i),
        .valid_i(exe_res_valid), .data_i(exe_res), .ready_o(exe_res_ready),
        .valid_o(res_valid), .data_o(res_rec), .ready_i(res_ready)
    );

    rv_result u_result (
        .clk(clk), .rst_i(rst_i),
        .res_valid_i(res_valid), .res_i(res_rec), .res_ready_o(res_ready),
        .rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
        .commit_valid_o(commit_valid_o), .commit_o(commit_o),
        .commit_credit_i(commit_credit_i)
    );

    rv_regfile u_regfile (
        .clk(clk), .rst_i(rst_i),
        .we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata),
        .raddr1_i(rs1_addr), .raddr2_i(rs2_addr),
        .rdata1_o(rs1_data), .rdata2_o(rs2_data)
    );

endmodule

// File: sim/tb_rv_core.sv
`include "rv_defines.svh"

module tb_rv_core;
    timeunit 1ns;
    timeprecision 1ps;

    import rv_pkg::*;

    // opcodes that the core must flag as illegal
    localparam logic [6:0] BAD_OPC [8] = '{7'h03, 7'h23, 7'h0f, 7'h73,
                                           7'h0b, 7'h2b, 7'h5b, 7'h7b};

    logic       clk = 1'b0;
    logic       rst_i;
    logic       in_valid_i = 1'b0;
    instr_pkt_t in_pkt_i = '0;
    logic       in_credit_o;
    logic       commit_valid_o;
    commit_t    commit_o;
    logic       commit_credit_i = 1'b0;

    rv_word_t   mregs [32] = '{default: 32'h0};   // reference register file
    rv_word_t   prog [$];
    commit_t    exp_q [$];
    int         acc_q [$];                        // acceptance cycle per packet
    rv_word_t   send_pc = 32'h0000_1000;
    int         send_idx;
    int         up_credits = `RV_IN_DEPTH;
    int         cyc;
    int         n_sent;
    int         n_commit;
    int         n_returned;
    int         owed;
    int         hold;
    int         errors;
    int         assert_fails;
    int         tests_passed;
    int         tests_failed;
    bit         stress_mode;
    logic [4:0] last_rd = 5'd1;

    always #2 clk = ~clk;

    rv_core u_dut (
        .clk(clk), .rst_i(rst_i),
        .in_valid_i(in_valid_i), .in_pkt_i(in_pkt_i), .in_credit_o(in_credit_o),
        .commit_valid_o(commit_valid_o), .commit_o(commit_o),
        .commit_credit_i(commit_credit_i)
    );

    function automatic rv_word_t make_ins(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    // small register set so dependencies come up often
    function automatic logic [4:0] pick_reg();
        return 5'($urandom_range(0, 3));
    endfunction

    function automatic rv_word_t alu_ref(input logic [2:0] f3, input logic alt,
                                         input rv_word_t a, input rv_word_t b);
        rv_word_t r;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: r = (a < b) ? 32'd1 : 32'd0;
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) r = $signed(a) >>> b[4:0];
                else r = a >> b[4:0];
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // f3[2:1] picks eq, lt or ltu; f3[0] inverts
    function automatic logic branch_ref(input logic [2:0] f3, input rv_word_t a,
                                        input rv_word_t b);
        logic base;
        base = f3[2] ? (f3[1] ? (a < b) : ($signed(a) < $signed(b))) : (a == b);
        return base ^ f3[0];
    endfunction

    function automatic commit_t predict_commit(input rv_word_t pc, input rv_word_t ins);
        commit_t    c;
        rv_word_t   a;
        rv_word_t   b;
        rv_word_t   imm_i;
        rv_word_t   imm_u;
        rv_word_t   imm_b;
        rv_word_t   imm_j;
        logic [2:0] f3;
        a     = mregs[ins[19:15]];
        b     = mregs[ins[24:20]];
        f3    = ins[14:12];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_u = {ins[31:12], 12'h000};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        c         = '0;
        c.pc      = pc;
        c.instr   = ins;
        c.rd      = ins[11:7];
        c.rd_we   = 1'b1;
        c.next_pc = pc + 32'd4;
        case (ins[6:0])
            OPC_OP:     c.rd_val = alu_ref(f3, ins[30], a, b);
            OPC_OP_IMM: c.rd_val = alu_ref(f3, ins[30] && f3 == 3'd5, a, imm_i);
            OPC_LUI:    c.rd_val = imm_u;
            OPC_AUIPC:  c.rd_val = pc + imm_u;
            OPC_JAL: begin
                c.rd_val  = pc + 32'd4;
                c.taken   = 1'b1;
                c.next_pc = pc + imm_j;
            end
            OPC_JALR: begin
                c.rd_val  = pc + 32'd4;
                c.taken   = 1'b1;
                c.next_pc = (a + imm_i) & 32'hffff_fffe;
            end
            OPC_BRANCH: begin
                c.rd_we = 1'b0;
                c.taken = branch_ref(f3, a, b);
                if (c.taken) c.next_pc = pc + imm_b;
            end
            default: begin
                c.rd_we   = 1'b0;
                c.illegal = 1'b1;
            end
        endcase
        if (c.rd == 5'd0) c.rd_we = 1'b0;
        if (c.rd_we) mregs[c.rd] = c.rd_val;
        return c;
    endfunction

    task automatic add_alu();
        rv_word_t   r;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [4:0] rs1;
        logic [4:0] rd;
        r   = $urandom;
        f3  = r[2:0];
        rs1 = r[5] ? last_rd : pick_reg();   // chain on the previous result
        rd  = pick_reg();
        if (r[3]) begin
            f7 = (f3 == 3'd5) ? {1'b0, r[4], 5'd0} : (f3 == 3'd1) ? 7'h00 : r[31:25];
            prog.push_back(make_ins(f7, r[24:20], rs1, f3, rd, OPC_OP_IMM));
        end else begin
            f7 = ((f3 == 3'd0 || f3 == 3'd5) && r[4]) ? 7'h20 : 7'h00;
            prog.push_back(make_ins(f7, pick_reg(), rs1, f3, rd, OPC_OP));
        end
        last_rd = rd;
    endtask

    task automatic add_upper_jump();
        rv_word_t   r;
        logic [4:0] rd;
        r  = $urandom;
        rd = pick_reg();
        case (r[1:0])
            2'd0: prog.push_back(make_ins(r[31:25], r[24:20], r[19:15], r[14:12], rd, OPC_LUI));
            2'd1: prog.push_back(make_ins(r[31:25], r[24:20], r[19:15], r[14:12], rd, OPC_AUIPC));
            2'd2: prog.push_back(make_ins(r[31:25], r[24:20], r[19:15], r[14:12], rd, OPC_JAL));
            default: prog.push_back(make_ins(r[31:25], r[24:20], pick_reg(), 3'd0, rd, OPC_JALR));
        endcase
        last_rd = rd;
    endtask

    task automatic add_branch();
        rv_word_t   r;
        logic [2:0] f3;
        r  = $urandom;
        f3 = r[2:0];
        if (f3[2:1] == 2'b01) f3[2] = 1'b1;   // 010 and 011 are not branches
        if (r[8]) begin
            // small values so equal operands show up
            prog.push_back(make_ins(7'h00, {3'b000, r[10:9]}, 5'd0, 3'd0, pick_reg(), OPC_OP_IMM));
        end
        prog.push_back(make_ins(r[31:25], pick_reg(), pick_reg(), f3, r[15:11], OPC_BRANCH));
    endtask

    task automatic add_illegal();
        rv_word_t r;
        r = $urandom;
        prog.push_back(make_ins(r[31:25], pick_reg(), pick_reg(), r[14:12], pick_reg(),
                                BAD_OPC[r[2:0]]));
        if (r[3]) add_alu();   // reads back the registers it must not touch
    endtask

    task automatic send_next();
        in_pkt_i.pc    = send_pc;
        in_pkt_i.instr = prog[send_idx];
        in_valid_i     = 1'b1;
        exp_q.push_back(predict_commit(send_pc, prog[send_idx]));
        acc_q.push_back(cyc + 1);   // taken at the coming rising edge
        send_idx++;
        n_sent++;
        up_credits--;
        send_pc += 32'd4;
    endtask

    task automatic check_field(input string name, input rv_word_t exp, input rv_word_t got);
        assert (exp == got) else begin
            $display("CHECK FAILED %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_commit();
        commit_t e;
        int      acc;
        n_commit++;
        owed++;
        if (exp_q.size() == 0) begin
            $display("commit arrived with no instruction outstanding");
            errors++;
            return;
        end
        e   = exp_q.pop_front();
        acc = acc_q.pop_front();
        check_field("commit_o.pc", e.pc, commit_o.pc);   // pc order is program order
        check_field("commit_o.instr", e.instr, commit_o.instr);
        check_field("commit_o.rd_we", 32'(e.rd_we), 32'(commit_o.rd_we));
        check_field("commit_o.illegal", 32'(e.illegal), 32'(commit_o.illegal));
        check_field("commit_o.taken", 32'(e.taken), 32'(commit_o.taken));
        check_field("commit_o.next_pc", e.next_pc, commit_o.next_pc);
        if (e.rd_we) begin
            check_field("commit_o.rd", 32'(e.rd), 32'(commit_o.rd));
            check_field("commit_o.rd_val", e.rd_val, commit_o.rd_val);
        end
        if (!stress_mode) begin
            assert (cyc - acc == 3) else begin
                $display("commit of pc %h came %0d cycles after acceptance instead of 3",
                         e.pc, cyc - acc);
                errors++;
            end
        end
    endtask

    task automatic return_credit();
        commit_credit_i = 1'b0;
        if (hold > 0) begin
            hold--;
        end else if (stress_mode && $urandom_range(0, 39) == 0) begin
            hold = $urandom_range(8, 30);   // sink stalls for a while
        end else if (owed > 0 && (!stress_mode || $urandom_range(0, 2) == 0)) begin
            commit_credit_i = 1'b1;
            owed--;
            n_returned++;
        end
    endtask

    always @(negedge clk) begin
        if (in_credit_o) up_credits++;
        in_valid_i = 1'b0;
        if (up_credits > 0 && send_idx < prog.size()) send_next();
        if (commit_valid_o) check_commit();
        return_credit();
    end

    always @(posedge clk) begin
        cyc++;
        if (cyc > 20 * n_sent + 200) begin
            $display("timeout after %0d cycles with %0d of %0d instructions committed",
                     cyc, n_commit, n_sent);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    a_quiet_until_first: assert property (@(posedge clk) disable iff (rst_i)
        (n_sent == 0) |-> (!commit_valid_o && !in_credit_o))
        else begin
            $display("commit or input credit seen before the first packet");
            assert_fails++;
        end

    a_commit_credit_bound: assert property (@(posedge clk) disable iff (rst_i)
        n_commit <= n_returned + `RV_COMMIT_CREDITS)
        else begin
            $display("more commits than commit credits allow");
            assert_fails++;
        end

    task automatic run_test(input string name, input bit stress);
        int err0;
        err0        = errors + assert_fails;
        stress_mode = stress;
        do @(posedge clk);
        while (send_idx < prog.size() || exp_q.size() != 0 || owed != 0 || hold != 0);
        if (errors + assert_fails == err0) begin
            tests_passed++;
            $display("test %s passed, %0d instructions sent so far", name, n_sent);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, errors + assert_fails - err0);
        end
    endtask

    initial begin
        bit ok;
        void'($urandom(32'ha37a_f6a8));
        rst_i = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        @(posedge clk);

        // x0 keeps zero whatever is written to it
        prog.push_back(make_ins(7'h3f, 5'h13, 5'd0, 3'd0, 5'd1, OPC_OP_IMM));
        prog.push_back(make_ins(7'h02, 5'h15, 5'd1, 3'd0, 5'd0, OPC_OP_IMM));
        prog.push_back(make_ins(7'h5a, 5'h0c, 5'h1f, 3'd3, 5'd0, OPC_LUI));
        prog.push_back(make_ins(7'h00, 5'd1, 5'd0, 3'd0, 5'd2, OPC_OP));
        prog.push_back(make_ins(7'h00, 5'd0, 5'd0, 3'd6, 5'd3, OPC_OP));
        run_test("x0_and_reset", 1'b0);

        repeat (48) add_alu();
        run_test("alu_chains", 1'b0);

        repeat (32) begin
            add_upper_jump();
            add_alu();
        end
        run_test("upper_and_jumps", 1'b0);

        repeat (40) add_branch();
        run_test("branches", 1'b0);

        repeat (32) add_illegal();
        run_test("illegal_opcodes", 1'b0);

        repeat (120) begin
            case ($urandom_range(0, 3))
                0: add_alu();
                1: add_upper_jump();
                2: add_branch();
                default: add_illegal();
            endcase
        end
        run_test("credit_backpressure", 1'b1);

        ok = (errors == 0) && (assert_fails == 0);
        assert (n_commit == n_sent) else begin
            $display("%0d commits seen for %0d packets sent", n_commit, n_sent);
            ok = 1'b0;
        end
        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (ok && tests_failed == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+include
hdl/rv_pkg.sv
hdl/rv_input_queue.sv
hdl/rv_pipe_reg.sv
hdl/rv_regfile.sv
hdl/rv_decode.sv
hdl/rv_execute.sv
hdl/rv_result.sv
hdl/rv_core.sv
sim/tb_rv_core.sv

// File: run_sim.sh
#!/bin/sh
verilator --binary --timing --assert -f sim.f --top-module tb_rv_core -o tb_rv_core \
    && ./obj_dir/tb_rv_core | tee /dev/stderr | grep -q "RESULT: PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
